// File: src/rv32i_types.sv
`default_nettype none

package rv32i_types;

    // Instruction address or data word
    typedef logic [31:0] rv32i_word;

endpackage : rv32i_types

`default_nettype wire

// File: src/bp_pkg.sv
`default_nettype none

package bp_pkg;

    localparam int pc_offset     = 2;  // Instruction alignment bits
    localparam int chooser_idx_w = 5;
    localparam int ghist_w       = 7;
    localparam int lht_idx_w     = 5;
    localparam int lhist_w       = 5;

    // Two-bit direction counter, top bit is the prediction
    typedef enum logic [1:0] {
        snt,
        wnt,
        wt,
        st
    } counter_t;

    // Tournament selector
    typedef enum logic [1:0] {
        sl,
        wl,
        wg,
        sg
    } chooser_t;

    typedef logic [ghist_w-1:0] ghist_t;
    typedef logic [lhist_w-1:0] lhist_t;

    localparam counter_t counter_reset = wnt;
    localparam chooser_t chooser_reset = wl;
    localparam lhist_t   lhist_reset   = '0;

    // Saturating step toward the resolved outcome
    function automatic counter_t count_next(counter_t c, logic taken);
        counter_t n;
        n = c;
        unique case (c)
            snt: n = taken ? wnt : snt;
            wnt: n = taken ? wt  : snt;
            wt:  n = taken ? st  : wnt;
            st:  n = taken ? st  : wt;
            default: n = c;
        endcase
        return n;
    endfunction

endpackage : bp_pkg

`default_nettype wire

// File: src/bp_table.sv
`timescale 1ns/1ps
`default_nettype none

module bp_table #(
    parameter type    entry_t     = logic [1:0],
    parameter int     idx_w       = 5,
    parameter entry_t reset_value = entry_t'(0)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [idx_w-1:0] ridx,
    output entry_t           rdata,
    input  logic             we,
    input  logic [idx_w-1:0] widx,
    input  entry_t           wdata
);

    entry_t mem [2**idx_w];

    assign rdata = mem[ridx];  // Asynchronous read, no write bypass

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**idx_w; i++) begin
                mem[i] <= reset_value;
            end
        end else if (we) begin
            mem[widx] <= wdata;
        end
    end

endmodule : bp_table

`default_nettype wire

// File: src/gbht.sv
`timescale 1ns/1ps
`default_nettype none

module gbht
    import rv32i_types::*;
    import bp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      update,
    input  logic      br_en,
    input  rv32i_word raddr,
    input  rv32i_word waddr,
    output logic      br_take,
    output logic      mispred
);

    ghist_t   ghist;
    ghist_t   ridx, widx;
    counter_t rcnt, wcnt;
    counter_t wcnt_next;

    // gshare index: PC bits folded with global history
    assign ridx = raddr[pc_offset +: ghist_w] ^ ghist;
    assign widx = waddr[pc_offset +: ghist_w] ^ ghist;

    assign wcnt_next = count_next(wcnt, br_en);

    // Pattern table copy serving fetch
    bp_table #(
        .entry_t    (counter_t),
        .idx_w      (ghist_w),
        .reset_value(counter_reset)
    ) pht_r_i (
        .clk,
        .rst,
        .ridx (ridx),
        .rdata(rcnt),
        .we   (update),
        .widx (widx),
        .wdata(wcnt_next)
    );

    // Pattern table copy serving resolve, written in lockstep
    bp_table #(
        .entry_t    (counter_t),
        .idx_w      (ghist_w),
        .reset_value(counter_reset)
    ) pht_w_i (
        .clk,
        .rst,
        .ridx (widx),
        .rdata(wcnt),
        .we   (update),
        .widx (widx),
        .wdata(wcnt_next)
    );

    assign br_take = rcnt[1];
    assign mispred = wcnt[1] ^ br_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            ghist <= '0;
        end else if (update) begin
            ghist <= {ghist[ghist_w-2:0], br_en};  // Newest outcome in bit 0
        end
    end

endmodule : gbht

`default_nettype wire

// File: src/lbht.sv
`timescale 1ns/1ps
`default_nettype none

module lbht
    import rv32i_types::*;
    import bp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      update,
    input  logic      br_en,
    input  rv32i_word raddr,
    input  rv32i_word waddr,
    output logic      br_take,
    output logic      mispred
);

    logic [lht_idx_w-1:0] r_row, w_row;
    lhist_t   rhist, whist;
    lhist_t   whist_next;
    counter_t rcnt, wcnt;
    counter_t wcnt_next;

    assign r_row = raddr[pc_offset +: lht_idx_w];
    assign w_row = waddr[pc_offset +: lht_idx_w];

    assign whist_next = {whist[lhist_w-2:0], br_en};
    assign wcnt_next  = count_next(wcnt, br_en);

    // Local history, fetch side
    bp_table #(
        .entry_t    (lhist_t),
        .idx_w      (lht_idx_w),
        .reset_value(lhist_reset)
    ) lht_r_i (
        .clk,
        .rst,
        .ridx (r_row),
        .rdata(rhist),
        .we   (update),
        .widx (w_row),
        .wdata(whist_next)
    );

    // Local history, resolve side
    bp_table #(
        .entry_t    (lhist_t),
        .idx_w      (lht_idx_w),
        .reset_value(lhist_reset)
    ) lht_w_i (
        .clk,
        .rst,
        .ridx (w_row),
        .rdata(whist),
        .we   (update),
        .widx (w_row),
        .wdata(whist_next)
    );

    // Counters indexed by the branch's own history
    bp_table #(
        .entry_t    (counter_t),
        .idx_w      (lhist_w),
        .reset_value(counter_reset)
    ) pht_r_i (
        .clk,
        .rst,
        .ridx (rhist),
        .rdata(rcnt),
        .we   (update),
        .widx (whist),
        .wdata(wcnt_next)
    );

    bp_table #(
        .entry_t    (counter_t),
        .idx_w      (lhist_w),
        .reset_value(counter_reset)
    ) pht_w_i (
        .clk,
        .rst,
        .ridx (whist),
        .rdata(wcnt),
        .we   (update),
        .widx (whist),  // Trained at the pre-update history
        .wdata(wcnt_next)
    );

    assign br_take = rcnt[1];
    assign mispred = wcnt[1] ^ br_en;

endmodule : lbht

`default_nettype wire

// File: src/tournament_p.sv
`timescale 1ns/1ps
`default_nettype none

module tournament_p
    import rv32i_types::*;
    import bp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      update,
    input  logic      br_en,
    input  rv32i_word raddr,
    input  rv32i_word waddr,
    output logic      br_take,
    output logic      mispred
);

    logic [chooser_idx_w-1:0] r_row, w_row;
    chooser_t r_state_q, w_state;
    chooser_t r_state, state_in;
    logic     g_br_take, l_br_take;
    logic     g_mispred, l_mispred;

    assign r_row = raddr[pc_offset +: chooser_idx_w];
    assign w_row = waddr[pc_offset +: chooser_idx_w];

    gbht gbht_i (
        .clk,
        .rst,
        .update,
        .br_en,
        .raddr,
        .waddr,
        .br_take(g_br_take),
        .mispred(g_mispred)
    );

    lbht lbht_i (
        .clk,
        .rst,
        .update,
        .br_en,
        .raddr,
        .waddr,
        .br_take(l_br_take),
        .mispred(l_mispred)
    );

    // Chooser copy for prediction
    bp_table #(
        .entry_t    (chooser_t),
        .idx_w      (chooser_idx_w),
        .reset_value(chooser_reset)
    ) chooser_r_i (
        .clk,
        .rst,
        .ridx (r_row),
        .rdata(r_state_q),
        .we   (update),
        .widx (w_row),
        .wdata(state_in)
    );

    // Chooser copy for resolve and training
    bp_table #(
        .entry_t    (chooser_t),
        .idx_w      (chooser_idx_w),
        .reset_value(chooser_reset)
    ) chooser_w_i (
        .clk,
        .rst,
        .ridx (w_row),
        .rdata(w_state),
        .we   (update),
        .widx (w_row),
        .wdata(state_in)
    );

    // Step away from the component that alone got it wrong
    always_comb begin
        state_in = w_state;
        if (update && (l_mispred ^ g_mispred)) begin
            unique case (w_state)
                sl: state_in = l_mispred ? wl : sl;
                wl: state_in = l_mispred ? wg : sl;
                wg: state_in = g_mispred ? wl : sg;
                sg: state_in = g_mispred ? wg : sg;
                default: state_in = w_state;
            endcase
        end
    end

    // Same row under update sees the new selector state
    assign r_state = (update && (r_row == w_row)) ? state_in : r_state_q;

    always_comb begin
        unique case (r_state)
            sl, wl:  br_take = l_br_take;
            default: br_take = g_br_take;
        endcase
    end

    always_comb begin
        unique case (w_state)
            sl, wl:  mispred = l_mispred;
            default: mispred = g_mispred;
        endcase
    end

endmodule : tournament_p

`default_nettype wire

// File: test/tournament_p_chk.sv
`timescale 1ns/1ps
`default_nettype none

module tournament_p_chk
    import bp_pkg::*;
(
    input logic                     clk,
    input logic                     rst,
    input logic                     update,
    input logic                     br_take,
    input logic                     mispred,
    input logic                     l_mispred,
    input logic                     g_mispred,
    input logic [chooser_idx_w-1:0] w_row,
    input logic [1:0]               w_state,
    input logic [1:0]               state_in
);

    int fail_count = 0;

    outputs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({br_take, mispred}))
    else begin
        $error("br_take or mispred is X or Z");
        fail_count++;
    end

    // Upper selector bit means global
    mispred_source: assert property (@(posedge clk) disable iff (rst)
        update |-> (mispred == (w_state[1] ? g_mispred : l_mispred)))
    else begin
        $error("mispred does not follow the selected component");
        fail_count++;
    end

    chooser_quiet: assert property (@(posedge clk) disable iff (rst)
        (!update ##1 $stable(w_row)) |-> $stable(w_state))
    else begin
        $error("Chooser entry changed without update");
        fail_count++;
    end

    chooser_one_step: assert property (@(posedge clk) disable iff (rst)
        update |-> ((state_in == w_state) || (state_in == w_state + 3'd1)
                    || (w_state == state_in + 3'd1)))
    else begin
        $error("Chooser moved more than one step");
        fail_count++;
    end

endmodule : tournament_p_chk

bind tournament_p tournament_p_chk chk_i (
    .clk,
    .rst,
    .update,
    .br_take,
    .mispred,
    .l_mispred,
    .g_mispred,
    .w_row,
    .w_state,
    .state_in
);

`default_nettype wire

// File: test/tournament_p_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tournament_p_tb
    import rv32i_types::*;
    import bp_pkg::*;
();

    localparam int clk_period     = 100;
    localparam int reset_cycles   = 16;
    localparam int reset_reads    = 16;
    localparam int loop_periods   = 12;
    localparam int loop_warmup    = 10;
    localparam int corr_pairs     = 60;
    localparam int step_periods   = 8;
    localparam int bypass_periods = 2;
    localparam int rand_cycles    = 500;
    localparam int test_cycles    = 6 * (reset_cycles + 1) + reset_reads + 2
        + 4 * loop_periods + 2 * corr_pairs + 7 * (step_periods + bypass_periods)
        + rand_cycles;
    localparam longint watchdog_ns = longint'(test_cycles) * clk_period * 2;

    logic      clk;
    logic      rst;
    logic      update;
    logic      br_en;
    rv32i_word raddr;
    rv32i_word waddr;
    logic      br_take;
    logic      mispred;

    integer seed = 32'hebf3_974f;

    // Reference predictor state
    logic [1:0]         m_gpht    [2**ghist_w];
    logic [1:0]         m_lpht    [2**lhist_w];
    logic [lhist_w-1:0] m_lht     [2**lht_idx_w];
    logic [1:0]         m_chooser [2**chooser_idx_w];
    logic [ghist_w-1:0] m_ghist;

    // Details of the most recent cycle, for test-specific checks
    logic       seen_take, seen_mis;
    logic       last_g_take, last_l_take, last_same_row;
    logic [1:0] last_sel_old, last_sel_new;

    tournament_p tournament_p_i (
        .clk,
        .rst,
        .update,
        .br_en,
        .raddr,
        .waddr,
        .br_take,
        .mispred
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_take(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: br_take expected %b, got %b", $time, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_mispred(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: mispred expected %b, got %b", $time, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [1:0] sat_step(logic [1:0] value, logic up);
        if (up) begin
            return (value == 2'b11) ? value : value + 2'b01;
        end
        return (value == 2'b00) ? value : value - 2'b01;
    endfunction

    task automatic model_reset();
        m_ghist = '0;
        foreach (m_gpht[i]) m_gpht[i] = counter_reset;
        foreach (m_lpht[i]) m_lpht[i] = counter_reset;
        foreach (m_lht[i]) m_lht[i] = lhist_reset;
        foreach (m_chooser[i]) m_chooser[i] = chooser_reset;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst    = 1'b1;
        update = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        model_reset();
    endtask

    // One cycle: drive, predict from the model, sample, then train the model
    task automatic step(input rv32i_word ra, input logic upd, input rv32i_word wa,
                        input logic en);
        logic [ghist_w-1:0]       gi_r, gi_w;
        logic [lht_idx_w-1:0]     lr_r, lr_w;
        logic [chooser_idx_w-1:0] cr_r, cr_w;
        logic [lhist_w-1:0]       lh_r, lh_w;
        logic                     g_mis, l_mis, exp_take, exp_mis;
        logic [1:0]               sel_w, sel_new, sel_r;
        @(negedge clk);
        raddr  = ra;
        update = upd;
        waddr  = wa;
        br_en  = en;
        gi_r = ra[pc_offset +: ghist_w] ^ m_ghist;
        gi_w = wa[pc_offset +: ghist_w] ^ m_ghist;
        lr_r = ra[pc_offset +: lht_idx_w];
        lr_w = wa[pc_offset +: lht_idx_w];
        cr_r = ra[pc_offset +: chooser_idx_w];
        cr_w = wa[pc_offset +: chooser_idx_w];
        lh_r = m_lht[lr_r];
        lh_w = m_lht[lr_w];
        g_mis = m_gpht[gi_w][1] ^ en;
        l_mis = m_lpht[lh_w][1] ^ en;
        sel_w   = m_chooser[cr_w];
        sel_new = (upd && (l_mis ^ g_mis)) ? sat_step(sel_w, l_mis) : sel_w;
        sel_r   = (upd && cr_r == cr_w) ? sel_new : m_chooser[cr_r];  // Same-row bypass
        last_g_take   = m_gpht[gi_r][1];
        last_l_take   = m_lpht[lh_r][1];
        last_same_row = (cr_r == cr_w);
        last_sel_old  = sel_w;
        last_sel_new  = sel_new;
        exp_take = sel_r[1] ? last_g_take : last_l_take;
        exp_mis  = sel_w[1] ? g_mis : l_mis;
        #(clk_period / 2 - 1);
        seen_take = br_take;
        seen_mis  = mispred;
        check_take(exp_take, seen_take);
        if (upd) check_mispred(exp_mis, seen_mis);
        @(posedge clk);
        if (upd) begin
            m_gpht[gi_w]    = sat_step(m_gpht[gi_w], en);
            m_lpht[lh_w]    = sat_step(m_lpht[lh_w], en);
            m_lht[lr_w]     = {lh_w[lhist_w-2:0], en};
            m_chooser[cr_w] = sel_new;
            m_ghist         = {m_ghist[ghist_w-2:0], en};
        end
    endtask

    task automatic test_after_reset();
        rv32i_word pc;
        apply_reset();
        for (int i = 0; i < reset_reads; i++) begin
            pc = $random(seed) & 32'hffff_fffc;
            step(pc, 1'b0, pc, 1'b0);
            check_take(1'b0, seen_take);
        end
        step(32'h0000_0010, 1'b1, 32'h0000_0010, 1'b0);
        check_mispred(1'b0, seen_mis);
        step(32'h0000_0024, 1'b1, 32'h0000_0024, 1'b1);
        check_mispred(1'b1, seen_mis);
    endtask

    // Taken three times, then not taken
    task automatic test_loop_branch();
        rv32i_word pc;
        pc = 32'h0000_0040;
        apply_reset();
        for (int p = 0; p < loop_periods; p++) begin
            for (int k = 0; k < 4; k++) begin
                step(pc, 1'b1, pc, k != 3);
                if (p >= loop_warmup) check_mispred(1'b0, seen_mis);
            end
        end
    endtask

    task automatic test_correlated_branch();
        rv32i_word  pa, pb;
        logic [31:0] r;
        pa = 32'h0000_0104;
        pb = 32'h0000_0228;
        apply_reset();
        for (int i = 0; i < corr_pairs; i++) begin
            r = $random(seed);
            step(pb, 1'b1, pa, r[0]);
            step(pa, 1'b1, pb, r[0]);  // Second branch repeats the first outcome
        end
    endtask

    // One taken, six not taken: local history is too short to see the taken one
    task automatic test_chooser_stepping();
        rv32i_word pc;
        int        crossings;
        pc = 32'h0000_0100;
        crossings = 0;
        apply_reset();
        for (int p = 0; p < step_periods; p++) begin
            for (int k = 0; k < 7; k++) begin
                step(pc, 1'b1, pc, k == 0);
                if (last_sel_old == 2'd1 && last_sel_new == 2'd2
                        && last_g_take != last_l_take) begin
                    crossings++;
                    check_take(last_g_take, seen_take);
                end
            end
        end
        if (crossings == 0) begin
            $display("Chooser never stepped to global while the two components disagreed");
            abort_run();
        end
    endtask

    task automatic test_same_row_bypass();
        rv32i_word pc;
        int        hits;
        pc = 32'h0000_0100;
        hits = 0;
        apply_reset();
        for (int p = 0; p < bypass_periods; p++) begin
            for (int k = 0; k < 7; k++) begin
                step(pc + 32'h100, 1'b1, pc, k == 0);  // Same chooser row, other gshare row
                if (last_same_row && last_sel_new[1] != last_sel_old[1]
                        && last_g_take != last_l_take) begin
                    hits++;
                    check_take(last_sel_new[1] ? last_g_take : last_l_take, seen_take);
                end
            end
        end
        if (hits == 0) begin
            $display("No update switched the selected component on the row being read");
            abort_run();
        end
    endtask

    task automatic test_random_mix();
        rv32i_word   ra, wa;
        logic [31:0] r;
        apply_reset();
        for (int i = 0; i < rand_cycles; i++) begin
            ra = $random(seed) & 32'h0000_03fc;
            wa = $random(seed) & 32'h0000_03fc;
            r  = $random(seed);
            step(ra, (i % 5) != 4, wa, r[0]);  // Four updates in every five cycles
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: run did not finish within %0d ns", watchdog_ns);
        abort_run();
    end

    initial begin
        rst    = 1'b1;
        update = 1'b0;
        br_en  = 1'b0;
        raddr  = '0;
        waddr  = '0;
        test_after_reset();
        test_loop_branch();
        test_correlated_branch();
        test_chooser_stepping();
        test_same_row_bypass();
        test_random_mix();
        if (tournament_p_i.chk_i.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Assertion checker reported %0d failures", tournament_p_i.chk_i.fail_count);
            abort_run();
        end
    end

endmodule : tournament_p_tb

`default_nettype wire

// File: verilog.f
src/rv32i_types.sv
src/bp_pkg.sv
src/bp_table.sv
src/gbht.sv
src/lbht.sv
src/tournament_p.sv
test/tournament_p_chk.sv
test/tournament_p_tb.sv
